// ==== hdl/core_fetch_pkg.sv ====
/*
 * Shared widths, constants and types of the instruction fetch stage.
 * Memory data is one doubleword wide and the buffer holds two of them.
 * FILL_* codes count the halfwords taken from the top of a doubleword.
 */

package core_fetch_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int XLEN        = 32;         // Control flow target width
    localparam int MEM_ADDR_W  = 32;         // Memory address width
    localparam int MEM_DATA_W  = 64;         // One doubleword per response
    localparam int BUF_BYTES   = 16;         // Alignment buffer capacity
    localparam int BUF_DEPTH_W = 5;          // Byte count 0..16
    localparam int INSTR_W     = 32;         // Instruction shown to decode
    localparam int FERR_W      = 2;          // One error bit per halfword

    // ----------------------------------------
    // Derived constants
    // ----------------------------------------
    localparam logic [MEM_ADDR_W-1:0]  PC_RESET_ADDRESS = 32'h1000_0000;
    localparam logic [BUF_DEPTH_W-1:0] DWORD_BYTES = BUF_DEPTH_W'(MEM_DATA_W / 8);
    localparam logic [BUF_DEPTH_W-1:0] REQ_ROOM    = BUF_DEPTH_W'(BUF_BYTES) - DWORD_BYTES;
    localparam logic [MEM_ADDR_W-1:0]  FETCH_STEP  = MEM_ADDR_W'(MEM_DATA_W / 8);

    // ----------------------------------------
    // Types
    // ----------------------------------------
    // Encoded as the number of halfwords loaded
    typedef enum logic [2:0] {
        FILL_NONE = 3'd0,                    // Nothing enters
        FILL_2    = 3'd1,                    // Top 2 bytes
        FILL_4    = 3'd2,                    // Top 4 bytes
        FILL_6    = 3'd3,                    // Top 6 bytes
        FILL_8    = 3'd4                     // Whole doubleword
    } fill_e;

    // Privilege sent with each request
    typedef enum logic [1:0] {
        PRV_U = 2'b01,                       // User
        PRV_M = 2'b10                        // Machine
    } prv_e;

endpackage

// ==== hdl/fetch_fill_if.sv ====
/*
 * Link between request controller and alignment buffer.
 * flush wins over fill and drain in the same cycle.
 */

`timescale 1ns/1ps

interface fetch_fill_if;

    logic                                  flush;    // Drop all buffered bytes
    logic                                  fill_en;  // Accepted doubleword this cycle
    core_fetch_pkg::fill_e                 fill;     // Top lanes to load
    logic [core_fetch_pkg::MEM_DATA_W-1:0] data;     // Response doubleword
    logic                                  error;    // Bus error on this response
    logic [core_fetch_pkg::BUF_DEPTH_W-1:0] depth;   // Bytes held now
    logic [core_fetch_pkg::BUF_DEPTH_W-1:0] n_depth; // Bytes held after this edge

    // Controller side
    modport ctrl (
        output flush, fill_en, fill, data, error,
        input  n_depth
    );

    // Buffer side
    modport buffer (
        input  flush, fill_en, fill, data, error,
        output depth, n_depth
    );

endinterface

// ==== hdl/fetch_req_ctrl.sv ====
/*
 * Fetch request controller. One request at a time on the memory port,
 * held with a stable address until granted. Responses come one cycle
 * after grant. Those granted before a control flow change are dropped.
 */

`timescale 1ns/1ps

module fetch_req_ctrl (
    input  logic                                  g_clk,
    input  logic                                  g_resetn,

    input  logic                                  cf_valid,   // Control flow change
    output logic                                  cf_ack,     // Change taken
    input  logic [core_fetch_pkg::XLEN-1:0]       cf_target,  // New halfword target

    input  logic                                  mode_m,     // Machine mode
    input  logic                                  mode_u,     // User mode

    output logic                                  imem_req,   // Request pending
    output logic [core_fetch_pkg::MEM_ADDR_W-1:0] imem_addr,  // Doubleword address
    output core_fetch_pkg::prv_e                  imem_prv,   // Request privilege
    input  logic                                  imem_gnt,   // Request accepted
    input  logic                                  imem_err,   // Response bus error
    input  logic [core_fetch_pkg::MEM_DATA_W-1:0] imem_rdata, // Response data

    fetch_fill_if.ctrl                            fill        // To alignment buffer
);

    // ----------------------------------------
    // Lane choice from halfword offset
    // ----------------------------------------
    function automatic core_fetch_pkg::fill_e lanes_from_offset(input logic [1:0] hw);
        core_fetch_pkg::fill_e lanes;
        case (hw)
            2'd0:    lanes = core_fetch_pkg::FILL_8; // Aligned target
            2'd1:    lanes = core_fetch_pkg::FILL_6;
            2'd2:    lanes = core_fetch_pkg::FILL_4;
            default: lanes = core_fetch_pkg::FILL_2; // Last halfword only
        endcase
        return lanes;
    endfunction

    // ----------------------------------------
    // Events
    // ----------------------------------------
    logic       e_cf_change;                  // Change accepted
    logic       e_imem_req;                   // Request granted
    logic       imem_recv;                    // Response on the bus now
    logic [1:0] outstanding;                  // Granted, not yet returned
    logic [1:0] n_outstanding;
    logic [1:0] discard;                      // Stale responses still to drop
    logic       fill_en;                      // Response goes into the buffer
    logic       buf_ready;                    // Room for a whole doubleword
    logic       n_imem_req;
    core_fetch_pkg::fill_e lane_sel;          // Lanes for the next useful response

    assign e_cf_change = cf_valid && cf_ack;
    assign e_imem_req  = imem_req && imem_gnt;

    // Address may only move when nothing is waiting for grant
    assign cf_ack = !imem_req || imem_gnt;

    // Machine privilege only when not running in user mode
    assign imem_prv = (mode_m && !mode_u) ? core_fetch_pkg::PRV_M : core_fetch_pkg::PRV_U;

    // ----------------------------------------
    // Request issue and address
    // ----------------------------------------
    // No new request in the grant cycle, its fill is not yet in n_depth
    assign buf_ready  = (fill.n_depth <= core_fetch_pkg::REQ_ROOM) && !e_imem_req;

    assign n_imem_req = buf_ready                 ||
                        (imem_req && !imem_gnt)   || // Hold until grant
                        e_cf_change;                 // Restart at new target

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            imem_req  <= 1'b0;
            imem_recv <= 1'b0;
            imem_addr <= core_fetch_pkg::PC_RESET_ADDRESS;
        end else begin
            imem_req  <= n_imem_req;
            imem_recv <= e_imem_req;                 // Fixed one cycle latency
            if (e_cf_change) begin
                imem_addr <= {cf_target[core_fetch_pkg::MEM_ADDR_W-1:3], 3'b000};
            end else if (e_imem_req) begin
                imem_addr <= imem_addr + core_fetch_pkg::FETCH_STEP;
            end
        end
    end

    // ----------------------------------------
    // Outstanding and stale responses
    // ----------------------------------------
    assign n_outstanding = outstanding + {1'b0, e_imem_req} - {1'b0, imem_recv};

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            outstanding <= 2'd0;
            discard     <= 2'd0;
        end else begin
            outstanding <= n_outstanding;
            if (e_cf_change) begin
                discard <= n_outstanding;            // Everything in flight is stale
            end else if (imem_recv && (discard != 2'd0)) begin
                discard <= discard - 2'd1;           // One stale response gone
            end
        end
    end

    assign fill_en = imem_recv && (discard == 2'd0);

    // ----------------------------------------
    // Fill lane selection
    // ----------------------------------------
    // First useful response after a change may start mid doubleword
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            lane_sel <= lanes_from_offset(core_fetch_pkg::PC_RESET_ADDRESS[2:1]);
        end else if (e_cf_change) begin
            lane_sel <= lanes_from_offset(cf_target[2:1]);
        end else if (fill_en) begin
            lane_sel <= core_fetch_pkg::FILL_8;      // Sequential from here on
        end
    end

    // ----------------------------------------
    // Buffer side
    // ----------------------------------------
    assign fill.flush   = e_cf_change;
    assign fill.fill_en = fill_en;
    assign fill.fill    = fill_en ? lane_sel : core_fetch_pkg::FILL_NONE;
    assign fill.data    = imem_rdata;               // Same cycle as imem_recv
    assign fill.error   = imem_err;

endmodule

// ==== hdl/core_pipe_fetch_buffer.sv ====
/*
 * 16-byte alignment buffer between memory and decode.
 * Bytes enter behind the current contents and leave from the front.
 * Callers keep fill within capacity and eat only a shown instruction.
 */

`timescale 1ns/1ps

module core_pipe_fetch_buffer (
    input  logic                               g_clk,
    input  logic                               g_resetn,

    fetch_fill_if.buffer                       fill,       // From request controller

    output logic                               s1_i16bit,  // 16-bit instruction shown
    output logic                               s1_i32bit,  // 32-bit instruction shown
    output logic [core_fetch_pkg::INSTR_W-1:0] s1_instr,   // Front four bytes
    output logic [core_fetch_pkg::FERR_W-1:0]  s1_ferr,    // Front halfword errors
    input  logic                               s1_eat_2,   // Decode takes 2 bytes
    input  logic                               s1_eat_4    // Decode takes 4 bytes
);

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    logic [core_fetch_pkg::BUF_BYTES*8-1:0]   data_q;      // Byte 0 at bits 7:0
    logic [core_fetch_pkg::BUF_BYTES/2-1:0]   err_q;       // One bit per halfword
    logic [core_fetch_pkg::BUF_DEPTH_W-1:0]   bytes_q;     // Valid byte count

    logic [core_fetch_pkg::BUF_BYTES*8-1:0]   n_data;
    logic [core_fetch_pkg::BUF_BYTES/2-1:0]   n_err;

    // ----------------------------------------
    // Fill and drain amounts
    // ----------------------------------------
    logic [2:0]                               fill_h;      // Halfwords entering
    logic [core_fetch_pkg::BUF_DEPTH_W-1:0]   fill_bytes;
    logic [core_fetch_pkg::BUF_DEPTH_W-1:0]   drain_bytes;
    logic [core_fetch_pkg::BUF_DEPTH_W-1:0]   rem;         // Bytes kept after drain
    logic [core_fetch_pkg::BUF_DEPTH_W-1:0]   skip_bytes;  // Low lanes not loaded
    logic [core_fetch_pkg::BUF_BYTES*8-1:0]   wide_in;     // Response zero extended
    logic [core_fetch_pkg::BUF_BYTES*8-1:0]   keep_mask;
    logic [core_fetch_pkg::BUF_BYTES/2-1:0]   keep_hmask;
    logic [core_fetch_pkg::BUF_BYTES/2-1:0]   in_hmask;

    assign fill_h      = (fill.fill_en && !fill.flush) ? fill.fill : 3'd0;
    assign fill_bytes  = {1'b0, fill_h, 1'b0};
    assign drain_bytes = s1_eat_4 ? 5'd4 :
                         s1_eat_2 ? 5'd2 : 5'd0;
    assign rem         = bytes_q - drain_bytes;
    assign skip_bytes  = core_fetch_pkg::DWORD_BYTES - fill_bytes;

    assign wide_in = {{(core_fetch_pkg::BUF_BYTES*8 - core_fetch_pkg::MEM_DATA_W){1'b0}},
                      fill.data};

    // Everything at and above rem is free space
    assign keep_mask  = ~({(core_fetch_pkg::BUF_BYTES*8){1'b1}} << {rem, 3'b000});
    assign keep_hmask = ~({(core_fetch_pkg::BUF_BYTES/2){1'b1}} << rem[4:1]);

    // Same error flag on every loaded halfword
    assign in_hmask   = {(core_fetch_pkg::BUF_BYTES/2){fill.error}} &
                        ~({(core_fetch_pkg::BUF_BYTES/2){1'b1}} << fill_h);

    // ----------------------------------------
    // Next contents
    // ----------------------------------------
    always_comb begin
        n_data = ((data_q >> {drain_bytes, 3'b000}) & keep_mask) |       // Shift out eaten
                 ((wide_in >> {skip_bytes, 3'b000}) << {rem, 3'b000});  // Top lanes behind
        n_err  = ((err_q >> drain_bytes[4:1]) & keep_hmask) |
                 (in_hmask << rem[4:1]);
    end

    assign fill.n_depth = fill.flush ? '0 : rem + fill_bytes; // Flush wins
    assign fill.depth   = bytes_q;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            bytes_q <= '0;
        end else begin
            bytes_q <= fill.n_depth;
        end
    end

    always_ff @(posedge g_clk) begin
        data_q <= n_data;                            // Bytes past the count are ignored
        err_q  <= n_err;
    end

    // ----------------------------------------
    // Length detection
    // ----------------------------------------
    // Low two bits 11 mark a 32-bit instruction
    assign s1_i16bit = (fill.depth >= 5'd2) && (data_q[1:0] != 2'b11);
    assign s1_i32bit = (fill.depth >= 5'd4) && (data_q[1:0] == 2'b11);

    assign s1_instr  = data_q[core_fetch_pkg::INSTR_W-1:0];
    assign s1_ferr   = err_q[core_fetch_pkg::FERR_W-1:0];   // Upper bit only for 32-bit

endmodule

// ==== hdl/core_pipe_fetch.sv ====
/*
 * Instruction fetch stage top. Memory, control flow and decode ports.
 * Decode eats 2 or 4 bytes only while the matching length flag is high.
 */

`timescale 1ns/1ps

module core_pipe_fetch (
    input  logic                                  g_clk,
    input  logic                                  g_resetn,

    // ----------------------------------------
    // Control flow
    // ----------------------------------------
    input  logic                                  cf_valid,    // Change requested
    output logic                                  cf_ack,      // Change taken
    input  logic [core_fetch_pkg::XLEN-1:0]       cf_target,   // Halfword aligned target

    input  logic                                  mode_m,      // Machine mode
    input  logic                                  mode_u,      // User mode

    // ----------------------------------------
    // Instruction memory
    // ----------------------------------------
    output logic                                  imem_req,
    output logic [core_fetch_pkg::MEM_ADDR_W-1:0] imem_addr,   // Doubleword aligned
    output core_fetch_pkg::prv_e                  imem_prv,
    input  logic                                  imem_gnt,
    input  logic                                  imem_err,    // Cycle after grant
    input  logic [core_fetch_pkg::MEM_DATA_W-1:0] imem_rdata,  // Cycle after grant

    // ----------------------------------------
    // Decode
    // ----------------------------------------
    output logic                                  s1_i16bit,
    output logic                                  s1_i32bit,
    output logic [core_fetch_pkg::INSTR_W-1:0]    s1_instr,
    output logic [core_fetch_pkg::FERR_W-1:0]     s1_ferr,
    input  logic                                  s1_eat_2,
    input  logic                                  s1_eat_4
);

    fetch_fill_if u_fill ();                                  // Controller to buffer

    fetch_req_ctrl u_req_ctrl (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .cf_valid   (cf_valid),
        .cf_ack     (cf_ack),
        .cf_target  (cf_target),
        .mode_m     (mode_m),
        .mode_u     (mode_u),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_prv   (imem_prv),
        .imem_gnt   (imem_gnt),
        .imem_err   (imem_err),
        .imem_rdata (imem_rdata),
        .fill       (u_fill.ctrl)
    );

    core_pipe_fetch_buffer u_buffer (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .fill       (u_fill.buffer),
        .s1_i16bit  (s1_i16bit),
        .s1_i32bit  (s1_i32bit),
        .s1_instr   (s1_instr),
        .s1_ferr    (s1_ferr),
        .s1_eat_2   (s1_eat_2),
        .s1_eat_4   (s1_eat_4)
    );

endmodule

// ==== verif/fetch_ref_model.svh ====
/*
 * Reference model of the fetch stage, included inside the testbench module.
 * Memory content is a hash of each halfword address, so 16-bit and 32-bit
 * instructions mix. Bus errors mark whole doublewords.
 */

`ifndef FETCH_REF_MODEL_SVH
`define FETCH_REF_MODEL_SVH

localparam logic [31:0] OUTSIDE_ERR_MASK = 32'h0000_0048; // Error when both bits set

// ----------------------------------------
// Memory image and error rule
// ----------------------------------------
function automatic logic [15:0] mem_half(input logic [31:0] addr);
    logic [31:0] h;
    h = (addr ^ 32'h5A5A_1234) * 32'h9E37_79B1;     // Mix the whole address
    h = h ^ (h >> 13);
    return h[31:16] ^ h[15:0];                      // Low bits vary per halfword
endfunction

function automatic logic [core_fetch_pkg::MEM_DATA_W-1:0] mem_dword(input logic [31:0] addr);
    logic [31:0] base;
    base = {addr[31:3], 3'b000};
    return {mem_half(base + 32'd6), mem_half(base + 32'd4),
            mem_half(base + 32'd2), mem_half(base)};   // Lowest address in low bits
endfunction

function automatic logic err_rule(input logic [31:0] addr);
    return ({addr[31:3], 3'b000} & OUTSIDE_ERR_MASK) == OUTSIDE_ERR_MASK;
endfunction

// ----------------------------------------
// Expected stream at a program counter
// ----------------------------------------
function automatic logic [core_fetch_pkg::INSTR_W-1:0] exp_instr(input logic [31:0] pc);
    return {mem_half(pc + 32'd2), mem_half(pc)};
endfunction

function automatic logic exp_is32(input logic [31:0] pc);
    logic [15:0] first;
    first = mem_half(pc);
    return first[1:0] == 2'b11;                     // RISC-V length encoding
endfunction

// Upper halfword may sit in the next doubleword
function automatic logic [core_fetch_pkg::FERR_W-1:0] exp_ferr(input logic [31:0] pc);
    return {err_rule(pc + 32'd2), err_rule(pc)};
endfunction

`endif

// ==== verif/tb_core_pipe_fetch.sv ====
/*
 * Testbench of the fetch stage. Grant delays, decode stalls and control
 * flow changes are random from a fixed seed and checked against the model
 * in fetch_ref_model.svh. Inputs change 2 ns after the rising edge.
 */

`timescale 1ns/1ps

module tb_core_pipe_fetch;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int TEST_CYCLES  = 3000;
    localparam int MARGIN       = 200;              // Watchdog slack in cycles
    localparam int DRIVE_DELAY  = 2;

    `include "fetch_ref_model.svh"

    logic                                  g_clk;
    logic                                  g_resetn;
    logic                                  cf_valid;
    logic                                  cf_ack;
    logic [core_fetch_pkg::XLEN-1:0]       cf_target;
    logic                                  mode_m;
    logic                                  mode_u;
    logic                                  imem_req;
    logic [core_fetch_pkg::MEM_ADDR_W-1:0] imem_addr;
    core_fetch_pkg::prv_e                  imem_prv;
    logic                                  imem_gnt;
    logic                                  imem_err;
    logic [core_fetch_pkg::MEM_DATA_W-1:0] imem_rdata;
    logic                                  s1_i16bit;
    logic                                  s1_i32bit;
    logic [core_fetch_pkg::INSTR_W-1:0]    s1_instr;
    logic [core_fetch_pkg::FERR_W-1:0]     s1_ferr;
    logic                                  s1_eat_2;
    logic                                  s1_eat_4;

    logic [31:0] exp_pc;                             // Model program counter
    logic [31:0] exp_req;                            // Next expected request address
    logic [31:0] rsp_q[$];                           // Granted, response due next cycle
    logic        req_prev;                           // imem_req last cycle
    logic        cf_prev;                            // Change taken last cycle
    logic        cf_done;                            // Drop cf_valid at next drive
    int          gnt_wait;                           // -1 when no grant delay chosen
    int          stall_left;                         // Long decode stall
    int          errors;
    int          checks;
    int          eaten;
    int          changes;

    core_pipe_fetch UUT (.*);

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic compare_instr(input logic [core_fetch_pkg::INSTR_W-1:0] got,
                                 input logic [core_fetch_pkg::INSTR_W-1:0] exp,
                                 input logic [core_fetch_pkg::INSTR_W-1:0] mask);
        checks++;
        if ((got & mask) !== (exp & mask)) begin
            errors++;
            $display("ERROR %0t: instruction at %h is %h, expected %h",
                     $time, exp_pc, got & mask, exp & mask);
        end
    endtask

    task automatic compare_len(input logic [1:0] got, input logic [1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: length flags (32,16) at %h are %b, expected %b",
                     $time, exp_pc, got, exp);
        end
    endtask

    task automatic compare_ferr(input logic [core_fetch_pkg::FERR_W-1:0] got,
                                input logic [core_fetch_pkg::FERR_W-1:0] exp,
                                input logic [core_fetch_pkg::FERR_W-1:0] mask);
        checks++;
        if ((got & mask) !== (exp & mask)) begin
            errors++;
            $display("ERROR %0t: error tag at %h is %b, expected %b",
                     $time, exp_pc, got & mask, exp & mask);
        end
    endtask

    task automatic compare_addr(input logic [core_fetch_pkg::MEM_ADDR_W-1:0] got,
                                input logic [core_fetch_pkg::MEM_ADDR_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: request address is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic compare_prv(input core_fetch_pkg::prv_e got,
                               input core_fetch_pkg::prv_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: request privilege is %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic print_counts();
        $display("Summary: %0d checks, %0d errors, %0d instructions, %0d changes",
                 checks, errors, eaten, changes);
    endtask

    // ----------------------------------------
    // Stimulus, 2 ns after the rising edge
    // ----------------------------------------
    task automatic drive_inputs();
        logic [31:0] rnd;
        logic [31:0] a;
        logic        stall;
        if (imem_req && gnt_wait < 0) begin
            gnt_wait = int'($urandom_range(3, 0)); // Grant delay 0..3
        end
        imem_gnt = imem_req && (gnt_wait == 0);
        if (gnt_wait > 0) begin
            gnt_wait--;
        end
        if (rsp_q.size() > 0) begin
            a          = rsp_q.pop_front();       // Response one cycle after grant
            imem_rdata = mem_dword(a);
            imem_err   = err_rule(a);
        end else begin
            imem_rdata = '0;
            imem_err   = 1'b0;
        end
        if (stall_left > 0) begin
            stall_left--;
        end else if ($urandom_range(99, 0) == 0) begin
            stall_left = int'($urandom_range(40, 10)); // Long decode stall
        end
        stall    = (stall_left > 0) || ($urandom_range(3, 0) == 0);
        s1_eat_2 = s1_i16bit && !stall;
        s1_eat_4 = s1_i32bit && !stall;
        if (cf_done) begin
            cf_valid = 1'b0;
            cf_done  = 1'b0;
        end
        if (!cf_valid && ($urandom_range(29, 0) == 0)) begin
            rnd       = $urandom();
            cf_valid  = 1'b1;                     // Held until cf_ack
            cf_target = core_fetch_pkg::PC_RESET_ADDRESS | (rnd & 32'h0000_0FFE);
            mode_u    = rnd[31];                  // Mode switch goes with the jump
            mode_m    = !rnd[31];
        end
    endtask

    // ----------------------------------------
    // Checks at the falling edge, then model update
    // ----------------------------------------
    task automatic check_cycle();
        logic is32;
        int   inflight;
        if (s1_i16bit || s1_i32bit) begin
            is32 = exp_is32(exp_pc);
            compare_len({s1_i32bit, s1_i16bit}, {is32, !is32});
            compare_instr(s1_instr, exp_instr(exp_pc), is32 ? 32'hFFFF_FFFF : 32'h0000_FFFF);
            compare_ferr(s1_ferr, exp_ferr(exp_pc), is32 ? 2'b11 : 2'b01);
        end
        // Only a request still waiting for grant holds off a change
        compare_flag(cf_ack, !(imem_req && !imem_gnt), "cf_ack");
        if (imem_req) begin
            compare_addr(imem_addr, exp_req);     // Also holds while waiting for grant
            compare_prv(imem_prv, mode_u ? core_fetch_pkg::PRV_U : core_fetch_pkg::PRV_M);
            if (!req_prev && !cf_prev) begin
                inflight = int'(exp_req - exp_pc);
                checks++;
                if (inflight > 8) begin
                    errors++;
                    $display("Request raised at %0t with %0d bytes already fetched",
                             $time, inflight);
                end
            end
        end
        req_prev = imem_req;
        cf_prev  = 1'b0;
        if (imem_req && imem_gnt) begin
            rsp_q.push_back(imem_addr);
            exp_req  = exp_req + 32'd8;
            gnt_wait = -1;
        end
        if (s1_eat_4 || s1_eat_2) begin
            exp_pc = exp_pc + (s1_eat_4 ? 32'd4 : 32'd2);
            eaten++;
        end
        if (cf_valid && cf_ack) begin
            exp_pc  = cf_target;                  // Change wins over an eat
            exp_req = {cf_target[31:3], 3'b000};
            cf_prev = 1'b1;
            cf_done = 1'b1;
            changes++;
        end
    endtask

    initial begin
        g_clk = 1'b0;
        forever #(CLK_PERIOD / 2) g_clk = ~g_clk;
    end

    initial begin
        #((RESET_CYCLES + TEST_CYCLES + MARGIN) * CLK_PERIOD);
        $display("Watchdog expired: the run did not end within the expected time");
        print_counts();
        $display("Regression failed");
        $finish;
    end

    initial begin
        void'($urandom(669));
        g_resetn   = 1'b0;
        cf_valid   = 1'b0;
        cf_target  = '0;
        mode_m     = 1'b1;
        mode_u     = 1'b0;
        imem_gnt   = 1'b0;
        imem_err   = 1'b0;
        imem_rdata = '0;
        s1_eat_2   = 1'b0;
        s1_eat_4   = 1'b0;
        exp_pc     = core_fetch_pkg::PC_RESET_ADDRESS;
        exp_req    = core_fetch_pkg::PC_RESET_ADDRESS;
        req_prev   = 1'b0;
        cf_prev    = 1'b0;
        cf_done    = 1'b0;
        gnt_wait   = -1;
        stall_left = 0;
        errors     = 0;
        checks     = 0;
        eaten      = 0;
        changes    = 0;
        repeat (RESET_CYCLES - 1) @(posedge g_clk);
        @(negedge g_clk);
        compare_flag(imem_req, 1'b0, "imem_req in reset");
        compare_len({s1_i32bit, s1_i16bit}, 2'b00);
        compare_addr(imem_addr, core_fetch_pkg::PC_RESET_ADDRESS);
        @(posedge g_clk);
        #DRIVE_DELAY g_resetn = 1'b1;
        repeat (TEST_CYCLES) begin
            @(posedge g_clk);
            #DRIVE_DELAY;
            drive_inputs();
            @(negedge g_clk);
            check_cycle();
        end
        if (eaten < TEST_CYCLES / 10) begin
            errors++;
            $display("Too few instructions consumed: %0d in %0d cycles", eaten, TEST_CYCLES);
        end
        print_counts();
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+verif
hdl/core_fetch_pkg.sv
hdl/fetch_fill_if.sv
hdl/fetch_req_ctrl.sv
hdl/core_pipe_fetch_buffer.sv
hdl/core_pipe_fetch.sv
verif/tb_core_pipe_fetch.sv

// ==== Makefile ====
# Verilator build and run of the fetch stage testbench

TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_core_pipe_fetch
FILELIST = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Regression failed
PASS_MSG = Regression passed

BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(BIN): $(FILELIST) $(wildcard hdl/*.sv) $(wildcard verif/*.sv) $(wildcard verif/*.svh)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: no result in $(LOG)"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
